/* source/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// data word width in bits
`define DCACHE_WORD_W 64

// byte address width
`define DCACHE_ADDR_W 32

`define DCACHE_WORDS_PER_LINE 4

// small on purpose so index conflicts are frequent
`define DCACHE_LINES 16

`endif

/* source/dcache_pkg.sv */
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

    localparam int offset_w = $clog2(`DCACHE_WORD_W / 8);
    localparam int word_sel_w = $clog2(`DCACHE_WORDS_PER_LINE);
    localparam int index_w = $clog2(`DCACHE_LINES);
    localparam int tag_w = `DCACHE_ADDR_W - index_w - word_sel_w - offset_w;
    localparam int line_w = `DCACHE_WORD_W * `DCACHE_WORDS_PER_LINE;
    localparam int line_addr_w = `DCACHE_ADDR_W - word_sel_w - offset_w;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0] strb_t;
    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
    typedef logic [line_w-1:0] line_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [word_sel_w-1:0] word_sel_t;
    typedef logic [tag_w-1:0] tag_t;
    typedef logic [line_addr_w-1:0] line_addr_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
    } cpu_req_t;

    typedef struct packed {
        logic valid;
        logic dirty;
    } line_flags_t;

    // writeback payload to L2
    typedef struct packed {
        line_addr_t addr;
        line_t      data;
    } l2_line_t;

    // address fields from the top are tag, index, word select and byte offset
    function automatic tag_t addr_tag(addr_t a);
        return a[`DCACHE_ADDR_W-1 -: tag_w];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[offset_w + word_sel_w +: index_w];
    endfunction

    function automatic word_sel_t addr_word_sel(addr_t a);
        return a[offset_w +: word_sel_w];
    endfunction

    function automatic line_addr_t addr_line(addr_t a);
        return a[`DCACHE_ADDR_W-1 -: line_addr_w];
    endfunction

endpackage

`default_nettype wire

/* source/line_store.sv */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_defs.svh"

module line_store #(
    parameter type entry_t = logic
) (
    input  wire logic              CLK,
    input  wire logic              wr_en,
    input  wire dcache_pkg::index_t wr_index,
    input  wire entry_t            wr_entry,
    input  wire dcache_pkg::index_t rd_index,
    output entry_t                 rd_entry
);

    entry_t mem [`DCACHE_LINES];

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_index] <= wr_entry;
        end
    end

    // registered read returns old contents on a same-index write
    always_ff @(posedge CLK) begin
        rd_entry <= mem[rd_index];
    end

endmodule

`default_nettype wire

/* source/line_state_bits.sv */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_defs.svh"

module line_state_bits (
    input  wire logic                    CLK,
    input  wire logic                    RST,
    input  wire logic                    wr_en,
    input  wire dcache_pkg::index_t      wr_index,
    input  wire dcache_pkg::line_flags_t wr_flags,
    input  wire dcache_pkg::index_t      rd_index,
    output dcache_pkg::line_flags_t      rd_flags
);

    logic [`DCACHE_LINES-1:0] valid_bits;
    logic [`DCACHE_LINES-1:0] dirty_bits;

    // every line invalid and clean after reset
    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr_en) begin
            valid_bits[wr_index] <= wr_flags.valid;
            dirty_bits[wr_index] <= wr_flags.dirty;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            rd_flags <= '0;
        end else begin
            rd_flags.valid <= valid_bits[rd_index];
            rd_flags.dirty <= dirty_bits[rd_index];
        end
    end

endmodule

`default_nettype wire

/* source/store_merge.sv */
`default_nettype none
`timescale 1ns/100ps

module store_merge (
    input  wire dcache_pkg::line_t     line,
    input  wire dcache_pkg::word_sel_t word_sel,
    input  wire dcache_pkg::word_t     wdata,
    input  wire dcache_pkg::strb_t     wstrb,
    output dcache_pkg::word_t          word,
    output dcache_pkg::line_t          merged
);

    import dcache_pkg::*;

    localparam int word_bits = $bits(word_t);
    localparam int bytes_per_word = $bits(strb_t);

    assign word = line[word_sel * word_bits +: word_bits];

    // only strobed bytes of the selected word change
    always_comb begin
        merged = line;
        for (int b = 0; b < bytes_per_word; b++) begin
            if (wstrb[b]) begin
                merged[word_sel * word_bits + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* source/miss_controller.sv */
`default_nettype none
`timescale 1ns/100ps

module miss_controller (
    input  wire logic                    CLK,
    input  wire logic                    RST,
    input  wire logic                    req_valid,
    input  wire dcache_pkg::cpu_req_t    req,
    output logic                         ready,
    output logic                         resp_valid,
    output dcache_pkg::word_t            rdata,
    output dcache_pkg::index_t           rd_index,
    input  wire dcache_pkg::tag_t        tag_out,
    input  wire dcache_pkg::line_t       line_out,
    input  wire dcache_pkg::line_flags_t flags_out,
    input  wire dcache_pkg::word_t       word,
    input  wire dcache_pkg::line_t       merged,
    output dcache_pkg::cpu_req_t         merge_req,
    output dcache_pkg::line_t            merge_line,
    output logic                         data_wr_en,
    output logic                         tag_wr_en,
    output dcache_pkg::index_t           wr_index,
    output dcache_pkg::line_t            wr_line,
    output dcache_pkg::tag_t             wr_tag,
    output logic                         flags_wr_en,
    output dcache_pkg::line_flags_t      wr_flags,
    output logic                         refill_req,
    output dcache_pkg::line_addr_t       refill_addr,
    input  wire logic                    refill_valid,
    input  wire dcache_pkg::line_t       refill_data,
    output logic                         wb_valid,
    output dcache_pkg::l2_line_t         wb,
    input  wire logic                    wb_done
);

    import dcache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_wb_wait,
        st_refill_wait
    } state_t;

    state_t   state;
    cpu_req_t req_q;
    logic     hit;

    assign ready = (state == st_idle);
    assign hit = flags_out.valid && (tag_out == addr_tag(req_q.addr));

    // index comes straight from the request while idle so lookup data is ready next cycle
    assign rd_index = ready ? addr_index(req.addr) : addr_index(req_q.addr);
    assign wr_index = addr_index(req_q.addr);
    assign wr_tag = addr_tag(req_q.addr);

    assign merge_req = req_q;
    assign merge_line = (state == st_refill_wait) ? refill_data : line_out;
    assign wr_line = req_q.write ? merged : merge_line;

    always_comb begin
        data_wr_en = 1'b0;
        tag_wr_en = 1'b0;
        flags_wr_en = 1'b0;
        wr_flags.valid = 1'b1;
        wr_flags.dirty = req_q.write;
        if (state == st_lookup && hit && req_q.write) begin
            data_wr_en = 1'b1;
            flags_wr_en = 1'b1;
        end
        // refill installs line, tag and flags together
        if (state == st_refill_wait && refill_valid) begin
            data_wr_en = 1'b1;
            tag_wr_en = 1'b1;
            flags_wr_en = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= st_idle;
            resp_valid <= 1'b0;
            refill_req <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            refill_req <= 1'b0;
            wb_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        req_q <= req;
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (hit) begin
                        resp_valid <= 1'b1;
                        rdata <= word;
                        state <= st_idle;
                    end else if (flags_out.valid && flags_out.dirty) begin
                        // victim address rebuilt from its stored tag
                        wb_valid <= 1'b1;
                        wb.addr <= {tag_out, addr_index(req_q.addr)};
                        wb.data <= line_out;
                        state <= st_wb_wait;
                    end else begin
                        refill_req <= 1'b1;
                        refill_addr <= addr_line(req_q.addr);
                        state <= st_refill_wait;
                    end
                end
                st_wb_wait: begin
                    if (wb_done) begin
                        refill_req <= 1'b1;
                        refill_addr <= addr_line(req_q.addr);
                        state <= st_refill_wait;
                    end
                end
                st_refill_wait: begin
                    if (refill_valid) begin
                        resp_valid <= 1'b1;
                        rdata <= word;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/dcache.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache (
    input  wire logic                 CLK,
    input  wire logic                 RST,
    input  wire logic                 req_valid,
    input  wire dcache_pkg::cpu_req_t req,
    output logic                      ready,
    output logic                      resp_valid,
    output dcache_pkg::word_t         rdata,
    output logic                      refill_req,
    output dcache_pkg::line_addr_t    refill_addr,
    input  wire logic                 refill_valid,
    input  wire dcache_pkg::line_t    refill_data,
    output logic                      wb_valid,
    output dcache_pkg::l2_line_t      wb,
    input  wire logic                 wb_done
);

    import dcache_pkg::*;

    index_t      rd_index;
    index_t      wr_index;
    tag_t        tag_out;
    tag_t        wr_tag;
    line_t       line_out;
    line_t       wr_line;
    line_t       merge_line;
    line_t       merged;
    line_flags_t flags_out;
    line_flags_t wr_flags;
    cpu_req_t    merge_req;
    word_t       word;
    logic        data_wr_en;
    logic        tag_wr_en;
    logic        flags_wr_en;

    line_store #(
        .entry_t (line_t)
    ) i_data_store (
        .CLK      (CLK),
        .wr_en    (data_wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_line),
        .rd_index (rd_index),
        .rd_entry (line_out)
    );

    line_store #(
        .entry_t (tag_t)
    ) i_tag_store (
        .CLK      (CLK),
        .wr_en    (tag_wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_tag),
        .rd_index (rd_index),
        .rd_entry (tag_out)
    );

    line_state_bits i_state_bits (
        .CLK      (CLK),
        .RST      (RST),
        .wr_en    (flags_wr_en),
        .wr_index (wr_index),
        .wr_flags (wr_flags),
        .rd_index (rd_index),
        .rd_flags (flags_out)
    );

    store_merge i_store_merge (
        .line     (merge_line),
        .word_sel (addr_word_sel(merge_req.addr)),
        .wdata    (merge_req.wdata),
        .wstrb    (merge_req.wstrb),
        .word     (word),
        .merged   (merged)
    );

    miss_controller i_miss_controller (
        .CLK          (CLK),
        .RST          (RST),
        .req_valid    (req_valid),
        .req          (req),
        .ready        (ready),
        .resp_valid   (resp_valid),
        .rdata        (rdata),
        .rd_index     (rd_index),
        .tag_out      (tag_out),
        .line_out     (line_out),
        .flags_out    (flags_out),
        .word         (word),
        .merged       (merged),
        .merge_req    (merge_req),
        .merge_line   (merge_line),
        .data_wr_en   (data_wr_en),
        .tag_wr_en    (tag_wr_en),
        .wr_index     (wr_index),
        .wr_line      (wr_line),
        .wr_tag       (wr_tag),
        .flags_wr_en  (flags_wr_en),
        .wr_flags     (wr_flags),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr),
        .refill_valid (refill_valid),
        .refill_data  (refill_data),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .wb_done      (wb_done)
    );

endmodule

`default_nettype wire

/* verification/l2_model.sv */
`default_nettype none
`timescale 1ns/100ps

module l2_model (
    input  wire logic                   CLK,
    input  wire logic [3:0]             latency,
    input  wire logic                   refill_req,
    input  wire dcache_pkg::line_addr_t refill_addr,
    output dcache_pkg::line_t           refill_data,
    output logic                        refill_valid,
    input  wire logic                   wb_valid,
    input  wire dcache_pkg::l2_line_t   wb,
    output logic                        wb_done
);

    import dcache_pkg::*;

    typedef logic [$bits(line_addr_t)+$bits(word_sel_t)-1:0] word_addr_t;

    localparam int word_bits = $bits(word_t);
    localparam int words_per_line = $bits(line_t) / $bits(word_t);
    localparam word_t fill_key = 64'h5a5a_c3c3_0ff0_9669;

    // words never written back keep the fill pattern
    word_t shadow [word_addr_t];

    function automatic word_t read_word(word_addr_t wa);
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return word_t'(wa) ^ fill_key;
    endfunction

    initial begin
        line_addr_t addr;
        refill_valid = 1'b0;
        refill_data = '0;
        forever begin
            @(posedge CLK);
            #1;
            if (refill_req) begin
                addr = refill_addr;
                repeat (latency) @(posedge CLK);
                #2;
                for (int w = 0; w < words_per_line; w++) begin
                    refill_data[w * word_bits +: word_bits] = read_word({addr, word_sel_t'(w)});
                end
                refill_valid = 1'b1;
                @(posedge CLK);
                #2;
                refill_valid = 1'b0;
            end
        end
    end

    initial begin
        l2_line_t victim;
        wb_done = 1'b0;
        forever begin
            @(posedge CLK);
            #1;
            if (wb_valid) begin
                victim = wb;
                for (int w = 0; w < words_per_line; w++) begin
                    shadow[{victim.addr, word_sel_t'(w)}] = victim.data[w * word_bits +: word_bits];
                end
                repeat (latency) @(posedge CLK);
                #2;
                wb_done = 1'b1;
                @(posedge CLK);
                #2;
                wb_done = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "dcache_defs.svh"

module dcache_tb;

    import dcache_pkg::*;

    typedef logic [$bits(addr_t)-4:0] word_addr_t;

    localparam int max_cycles = 8000;
    localparam int random_requests = 300;
    localparam int sel_lo = $clog2($bits(strb_t));
    localparam int idx_lo = sel_lo + $bits(word_sel_t);
    localparam int tag_lo = idx_lo + $bits(index_t);
    localparam int words_per_line = $bits(line_t) / $bits(word_t);
    localparam word_t fill_key = 64'h5a5a_c3c3_0ff0_9669;

    logic       CLK = 1'b0;
    logic       RST;
    logic       req_valid;
    cpu_req_t   req;
    logic       ready;
    logic       resp_valid;
    word_t      rdata;
    logic       refill_req;
    line_addr_t refill_addr;
    logic       refill_valid;
    line_t      refill_data;
    logic       wb_valid;
    l2_line_t   wb;
    logic       wb_done;
    logic [3:0] l2_latency;
    wire logic  accept;

    // expectations for the request in flight
    logic       exp_hit = 1'b0;
    logic       exp_wb = 1'b0;
    logic       exp_read = 1'b0;
    word_t      exp_rdata = '0;
    line_addr_t exp_refill_addr = '0;
    l2_line_t   exp_wb_line = '0;

    int         cycle_count = 0;
    int         outstanding;
    logic       wb_finished;
    logic       mir_valid [`DCACHE_LINES];
    logic       mir_dirty [`DCACHE_LINES];
    tag_t       mir_tag [`DCACHE_LINES];
    word_t      ref_mem [word_addr_t];
    tag_t       tag_pool [3] = '{23'h000010, 23'h02a51c, 23'h7f00c3};
    index_t     index_pool [4] = '{4'd0, 4'd5, 4'd9, 4'd15};

    assign accept = req_valid && ready;

    always #20 CLK = ~CLK;

    dcache i_dcache (
        .CLK          (CLK),
        .RST          (RST),
        .req_valid    (req_valid),
        .req          (req),
        .ready        (ready),
        .resp_valid   (resp_valid),
        .rdata        (rdata),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr),
        .refill_valid (refill_valid),
        .refill_data  (refill_data),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .wb_done      (wb_done)
    );

    l2_model i_l2_model (
        .CLK          (CLK),
        .latency      (l2_latency),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr),
        .refill_data  (refill_data),
        .refill_valid (refill_valid),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .wb_done      (wb_done)
    );

    task automatic value_error(string name, logic [511:0] expected, logic [511:0] actual);
        $display("ERROR %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic rule_error(string what);
        $display("FAILURE %0t ns %s", $time, what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic word_t mem_word(word_addr_t wa);
        if (ref_mem.exists(wa)) begin
            return ref_mem[wa];
        end
        return word_t'(wa) ^ fill_key;
    endfunction

    function automatic line_t mem_line(line_addr_t la);
        line_t l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w * $bits(word_t) +: $bits(word_t)] = mem_word({la, word_sel_t'(w)});
        end
        return l;
    endfunction

    task automatic merge_store(word_addr_t wa, word_t wdata, strb_t wstrb);
        word_t w;
        w = mem_word(wa);
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (wstrb[b]) begin
                w[b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
        ref_mem[wa] = w;
    endtask

    always @(posedge CLK) begin
        if (RST) begin
            outstanding <= 0;
            wb_finished <= 1'b0;
        end else begin
            outstanding <= outstanding + int'(accept) - int'(resp_valid);
            if (accept) begin
                wb_finished <= 1'b0;
            end else if (wb_done) begin
                wb_finished <= 1'b1;
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            rule_error("timeout, the run did not finish within the cycle limit");
        end
    end

    assert property (@(posedge CLK) $fell(RST) |-> ready && !resp_valid && !refill_req && !wb_valid)
        else rule_error("outputs not idle after reset");
    assert property (@(posedge CLK) disable iff (RST) req_valid |-> ready)
        else value_error("ready", 1, $sampled(ready));
    assert property (@(posedge CLK) disable iff (RST) accept && exp_hit |-> ##2 resp_valid)
        else value_error("resp_valid", 1, $sampled(resp_valid));
    assert property (@(posedge CLK) disable iff (RST) accept && exp_wb |-> ##2 wb_valid)
        else value_error("wb_valid", 1, $sampled(wb_valid));
    assert property (@(posedge CLK) disable iff (RST)
        accept && !exp_hit && !exp_wb |-> ##2 refill_req)
        else value_error("refill_req", 1, $sampled(refill_req));
    assert property (@(posedge CLK) disable iff (RST) wb_valid |-> exp_wb)
        else rule_error("writeback issued for a hit or a clean victim");
    assert property (@(posedge CLK) disable iff (RST) wb_valid |-> wb == exp_wb_line)
        else value_error("wb", exp_wb_line, $sampled(wb));
    assert property (@(posedge CLK) disable iff (RST) refill_req |-> !exp_hit)
        else rule_error("refill requested for a hit");
    assert property (@(posedge CLK) disable iff (RST) refill_req |-> wb_finished || !exp_wb)
        else rule_error("refill requested before the dirty victim writeback completed");
    assert property (@(posedge CLK) disable iff (RST) refill_req |-> refill_addr == exp_refill_addr)
        else value_error("refill_addr", exp_refill_addr, $sampled(refill_addr));
    assert property (@(posedge CLK) disable iff (RST) resp_valid && exp_read |-> rdata == exp_rdata)
        else value_error("rdata", exp_rdata, $sampled(rdata));
    assert property (@(posedge CLK) disable iff (RST) resp_valid |-> outstanding == 1)
        else rule_error("response pulse without exactly one accepted request");

    // drives one request and updates mirror and reference memory after its response
    task automatic cache_access(logic write, addr_t addr, word_t wdata, strb_t wstrb);
        index_t     idx;
        tag_t       tag;
        word_addr_t wa;
        idx = addr[idx_lo +: $bits(index_t)];
        tag = addr[tag_lo +: $bits(tag_t)];
        wa = addr[sel_lo +: $bits(word_addr_t)];
        exp_hit = mir_valid[idx] && (mir_tag[idx] == tag);
        exp_wb = !exp_hit && mir_valid[idx] && mir_dirty[idx];
        exp_wb_line.addr = {mir_tag[idx], idx};
        exp_wb_line.data = mem_line({mir_tag[idx], idx});
        exp_refill_addr = addr[idx_lo +: $bits(line_addr_t)];
        exp_read = !write;
        exp_rdata = mem_word(wa);
        l2_latency = 4'($urandom_range(1, 8));
        req = '{write: write, addr: addr, wdata: wdata, wstrb: wstrb};
        req_valid = 1'b1;
        @(posedge CLK);
        #2;
        req_valid = 1'b0;
        do begin
            @(posedge CLK);
            #2;
        end while (!resp_valid);
        mir_dirty[idx] = exp_hit ? (mir_dirty[idx] || write) : write;
        mir_valid[idx] = 1'b1;
        mir_tag[idx] = tag;
        if (write) begin
            merge_store(wa, wdata, wstrb);
        end
        @(posedge CLK);
        #2;
    endtask

    task automatic random_access();
        addr_t addr;
        strb_t strb;
        addr = '0;
        addr[tag_lo +: $bits(tag_t)] = tag_pool[$urandom_range(0, 2)];
        addr[idx_lo +: $bits(index_t)] = index_pool[$urandom_range(0, 3)];
        addr[sel_lo +: $bits(word_sel_t)] = word_sel_t'($urandom_range(0, 3));
        strb = ($urandom_range(0, 3) == 0) ? 8'hff : 8'($urandom_range(1, 254));
        if ($urandom_range(0, 1) == 1) begin
            cache_access(1'b1, addr, {$urandom(), $urandom()}, strb);
        end else begin
            cache_access(1'b0, addr, '0, '0);
        end
    endtask

    initial begin
        addr_t addr;
        void'($urandom(46021));
        RST = 1'b1;
        req_valid = 1'b0;
        req = '0;
        l2_latency = 4'd1;
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            mir_valid[i] = 1'b0;
            mir_dirty[i] = 1'b0;
            mir_tag[i] = '0;
        end
        repeat (5) @(posedge CLK);
        #2;
        RST = 1'b0;
        @(posedge CLK);
        #2;
        // first touch of every index misses
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            addr = '0;
            addr[tag_lo +: $bits(tag_t)] = tag_pool[0];
            addr[idx_lo +: $bits(index_t)] = index_t'(i);
            cache_access(1'b0, addr, '0, '0);
        end
        for (int n = 0; n < random_requests; n++) begin
            random_access();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* dcache.f */
+incdir+source
source/dcache_pkg.sv
source/line_store.sv
source/line_state_bits.sv
source/store_merge.sv
source/miss_controller.sv
source/dcache.sv
verification/l2_model.sv
verification/dcache_tb.sv
